// ==== bench/tb_cpu.sv ====
/*
 * testbench for the rv32i core
 * byte memory model, program table with a register model,
 * random rdy_in pauses, result and store checks, watchdog
 */
`timescale 1ns/1ns

module tb_cpu
  import cpu_pkg::*;
();

  typedef struct packed {
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;   // full value that encode slices into the format
  } step_t;

  logic        clk_in = 1'b0;
  logic        rst_in, rdy_in, io_buffer_full, mem_wr;
  logic [7:0]  mem_din, mem_dout, rd_q;
  logic [31:0] mem_a, dbgreg_dout;
  logic [7:0]  mem [0:131071];  // 128 KB
  logic [31:0] model_regs [32];
  step_t       steps[$];
  logic [31:0] exp_dbg[$], st_addr[$], st_data[$];
  logic [31:0] snap_a, last_dbg;
  logic        snap_wr;
  logic        addr_seen = 1'b0;
  logic        done = 1'b0;
  int          errors = 0, n_results = 0, n_bytes = 0, active = 0, limit = 0;
  int          seed = 46;
  int          s_idx, b_idx;

  always #50 clk_in = ~clk_in;  // 100 ns period

  cpu DUT (
    .clk_in, .rst_in, .rdy_in, .mem_din, .mem_dout, .mem_a, .mem_wr,
    .io_buffer_full, .dbgreg_dout
  );

  // ram with one cycle of read latency that answers every edge
  always @(posedge clk_in) begin
    if (mem_wr && mem_a < 32'h20000) mem[mem_a[16:0]] <= mem_dout;
    rd_q <= mem[mem_a[16:0]];
  end

  always @(negedge clk_in) mem_din <= rd_q;  // handed to the DUT on the falling edge

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
  endtask

  task automatic add_step(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7,
                          input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [31:0] imm);
    steps.push_back({op, f3, f7, rd, rs1, rs2, imm});
  endtask

  function automatic logic [31:0] encode(input step_t s);
    case (s.op)
      op_reg:           return {s.f7, s.rs2, s.rs1, s.f3, s.rd, s.op};
      op_lui, op_auipc: return {s.imm[31:12], s.rd, s.op};
      op_store:         return {s.imm[11:5], s.rs2, s.rs1, s.f3, s.imm[4:0], s.op};
      default:          return {s.imm[11:0], s.rs1, s.f3, s.rd, s.op};  // i-type
    endcase
  endfunction

  // rv32i integer ops by funct3 where alt selects sub and sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic fill_table;
    add_step(op_imm,   3'd0, 7'h00,  1,  0, 0, -32'sd5);        // negative operand
    add_step(op_imm,   3'd0, 7'h00,  2,  0, 0, 32'd3);
    add_step(op_lui,   3'd0, 7'h00,  3,  0, 0, 32'h12345000);
    add_step(op_auipc, 3'd0, 7'h00,  4,  0, 0, 32'h00001000);
    add_step(op_reg,   3'd0, 7'h00,  5,  1, 2, 32'd0);          // add
    add_step(op_reg,   3'd0, 7'h20,  6,  2, 1, 32'd0);          // sub
    add_step(op_reg,   3'd1, 7'h00,  7,  1, 2, 32'd0);          // sll
    add_step(op_reg,   3'd2, 7'h00,  8,  1, 2, 32'd0);          // slt
    add_step(op_reg,   3'd3, 7'h00,  9,  1, 2, 32'd0);          // sltu
    add_step(op_reg,   3'd4, 7'h00, 10,  1, 3, 32'd0);          // xor
    add_step(op_reg,   3'd5, 7'h00, 11,  1, 2, 32'd0);          // srl
    add_step(op_reg,   3'd5, 7'h20, 12,  1, 2, 32'd0);          // sra
    add_step(op_reg,   3'd6, 7'h00, 13,  2, 3, 32'd0);          // or
    add_step(op_reg,   3'd7, 7'h00, 14,  1, 3, 32'd0);          // and
    add_step(op_imm,   3'd0, 7'h00,  0,  1, 0, 32'd7);          // write to x0
    add_step(7'b0000011, 3'd2, 7'h00, 15, 0, 0, 32'd0);         // lw, unsupported
    add_step(op_reg,   3'd0, 7'h00, 16,  0, 2, 32'd0);          // reads x0
    add_step(op_lui,   3'd0, 7'h00, 17,  0, 0, 32'h00001000);
    add_step(op_store, 3'd2, 7'h00,  0, 17, 3, 32'd16);
    add_step(op_store, 3'd2, 7'h00,  0, 17, 1, -32'sd4);        // negative offset
    add_step(op_imm,   3'd0, 7'h00, 18,  0, 0, 32'h000007ab);
    add_step(op_lui,   3'd0, 7'h00, 19,  0, 0, 32'h00030000);
    add_step(op_store, 3'd2, 7'h00,  0, 19, 2, 32'd4);          // 0x30004 ends the run
  endtask

  // place the words at 0 and run the register model over the table
  task automatic load_program;
    step_t       s;
    logic [31:0] word, a, b, res;
    logic        writes;
    for (int i = 0; i < steps.size(); i++) begin
      s      = steps[i];
      word   = encode(s);
      a      = model_regs[s.rs1];
      b      = model_regs[s.rs2];
      res    = '0;
      writes = 1'b1;
      for (int k = 0; k < 4; k++) begin
        mem[i*4 + k] = word[8*k +: 8];  // little-endian
      end
      case (s.op)
        op_imm:   res = alu_ref(s.f3, s.f3 == 3'd5 && s.imm[10], a, s.imm);
        op_reg:   res = alu_ref(s.f3, s.f7[5], a, b);
        op_lui:   res = s.imm;
        op_auipc: res = 32'(i * 4) + s.imm;
        op_store: begin
          writes = 1'b0;
          st_addr.push_back(a + s.imm);
          st_data.push_back(b);
        end
        default:  writes = 1'b0;  // no-op
      endcase
      if (writes && s.rd != 5'd0) begin
        model_regs[s.rd] = res;
        exp_dbg.push_back(res);
      end
    end
  endtask

  initial begin
    rst_in         = 1'b1;
    rdy_in         = 1'b1;
    io_buffer_full = 1'b0;
    mem_din        = 8'h00;
    for (int i = 0; i < 131072; i++) begin
      mem[i] = 8'h00;  // zero words decode as no-ops
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    fill_table();
    load_program();
    limit = steps.size() * 20 + 200;
    repeat (8) begin
      @(negedge clk_in);
      if (mem_wr !== 1'b0) report_mismatch("mem_wr", {31'b0, mem_wr}, 32'd0);
      if (dbgreg_dout !== 32'd0) report_mismatch("dbgreg_dout", dbgreg_dout, 32'd0);
    end
    rst_in   = 1'b0;
    snap_a   = mem_a;
    snap_wr  = mem_wr;
    last_dbg = dbgreg_dout;
    while (!done) begin
      @(negedge clk_in);
      if (!rdy_in) begin  // last edge was paused
        if (mem_a !== snap_a) report_mismatch("mem_a", mem_a, snap_a);
        if (mem_wr !== snap_wr) report_mismatch("mem_wr", {31'b0, mem_wr}, {31'b0, snap_wr});
      end
      if (!addr_seen && mem_a !== 32'd0) begin
        addr_seen = 1'b1;
        if (mem_a !== 32'd1) report_mismatch("mem_a", mem_a, 32'd1);  // fetch starts at 0
      end
      if (dbgreg_dout !== last_dbg) begin
        if (!rdy_in) begin
          errors++;
          $display("error at %0t ns: dbgreg_dout changed while rdy_in was low", $time);
        end
        if (n_results >= exp_dbg.size()) begin
          errors++;
          $display("error at %0t ns: register write %h beyond the program", $time, dbgreg_dout);
        end else if (dbgreg_dout !== exp_dbg[n_results]) begin
          report_mismatch("dbgreg_dout", dbgreg_dout, exp_dbg[n_results]);
        end
        n_results++;
      end
      snap_a   = mem_a;
      snap_wr  = mem_wr;
      last_dbg = dbgreg_dout;
      rdy_in   = (($random(seed) & 7) != 0);  // pause about one edge in eight
      if (rdy_in && mem_wr) begin  // this byte is taken at the coming edge
        s_idx = n_bytes / 4;
        b_idx = n_bytes % 4;
        if (s_idx >= st_addr.size()) begin
          errors++;
          $display("error at %0t ns: bus write at %h with no store pending", $time, mem_a);
        end else begin
          if (mem_a !== st_addr[s_idx] + b_idx)
            report_mismatch("mem_a", mem_a, st_addr[s_idx] + b_idx);
          if (mem_dout !== st_data[s_idx][8*b_idx +: 8])
            report_mismatch("mem_dout", {24'b0, mem_dout}, {24'b0, st_data[s_idx][8*b_idx +: 8]});
        end
        n_bytes++;
        if (mem_a === 32'h00030007) done = 1'b1;
      end
    end
    @(negedge clk_in);
    for (int s = 0; s < st_addr.size(); s++) begin
      for (int k = 0; k < 4; k++) begin
        if (st_addr[s] < 32'h20000 && mem[st_addr[s] + k] !== st_data[s][8*k +: 8])
          report_mismatch($sformatf("mem[%h]", st_addr[s] + k),
                          {24'b0, mem[st_addr[s] + k]}, {24'b0, st_data[s][8*k +: 8]});
      end
    end
    if (n_results != exp_dbg.size()) begin
      errors++;
      $display("error: %0d of %0d register results seen", n_results, exp_dbg.size());
    end
    if (n_bytes != 4 * st_addr.size()) begin
      errors++;
      $display("error: %0d store bytes written, %0d expected", n_bytes, 4 * st_addr.size());
    end
    $display("%0d errors, %0d results, %0d store bytes", errors, n_results, n_bytes);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // budget counted in active edges only
  initial begin
    wait (rst_in === 1'b0);
    while (active < limit) begin
      @(posedge clk_in);
      if (rdy_in) active++;
    end
    $display("timeout: the final store was not reached within %0d active cycles", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== rtl/alu_exec.sv ====
/*
 * execute stage
 * runs the selected alu operation and registers the result,
 * for sw it sends address and data to the bus sequencer for one cycle
 */
`timescale 1ns/1ns

module alu_exec
  import cpu_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       rdy_in,
  input  decoded_t   dec_out,
  output exec_t      exec_out,
  output store_req_t store_req
);

  logic [xlen-1:0] result;
  logic [4:0]      shamt;

  assign shamt = dec_out.op_b[4:0];  // shifts use the low 5 bits

  always_comb begin
    case (dec_out.alu_op)
      alu_add:  result = dec_out.op_a + dec_out.op_b;  // also sw address
      alu_sub:  result = dec_out.op_a - dec_out.op_b;
      alu_sll:  result = dec_out.op_a << shamt;
      alu_slt:  result = xlen'($signed(dec_out.op_a) < $signed(dec_out.op_b));
      alu_sltu: result = xlen'(dec_out.op_a < dec_out.op_b);
      alu_xor:  result = dec_out.op_a ^ dec_out.op_b;
      alu_srl:  result = dec_out.op_a >> shamt;
      alu_sra:  result = $signed(dec_out.op_a) >>> shamt;
      alu_or:   result = dec_out.op_a | dec_out.op_b;
      alu_and:  result = dec_out.op_a & dec_out.op_b;
      default:  result = dec_out.op_b;  // lui
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      exec_out  <= '0;
      store_req <= '0;
    end else if (rdy_in) begin
      exec_out.valid   <= dec_out.valid && !dec_out.is_store;
      exec_out.rd      <= dec_out.rd;
      exec_out.wr_en   <= dec_out.wr_en;
      exec_out.result  <= result;
      store_req.valid  <= dec_out.valid && dec_out.is_store;  // single-cycle strobe
      store_req.addr   <= result;
      store_req.data   <= dec_out.store_data;
    end
  end

endmodule

// ==== rtl/cpu.sv ====
/*
 * rv32i core top level
 * fetch, decode, execute and writeback around a byte-wide memory bus
 * the uart full flag is kept as a port only
 */
`timescale 1ns/1ns

module cpu
  import cpu_pkg::*;
(
  input  logic                 clk_in,          // system clock
  input  logic                 rst_in,          // synchronous active-high reset
  input  logic                 rdy_in,          // low pauses the whole core
  input  logic [7:0]           mem_din,         // byte read data
  output logic [7:0]           mem_dout,        // byte write data
  output logic [addr_bits-1:0] mem_a,           // byte address
  output logic                 mem_wr,          // 1 = write
  input  logic                 io_buffer_full,  // uart full flag ignored by the core
  output logic [xlen-1:0]      dbgreg_dout      // last register write
);

  logic                     fetch_req;
  logic [addr_bits-1:0]     fetch_addr;
  logic                     fetch_done;
  logic [xlen-1:0]          fetch_word;
  logic                     store_busy;
  store_req_t               store_req;
  fetch_t                   fetch_out;
  decoded_t                 dec_out;
  exec_t                    exec_out;
  logic [reg_addr_bits-1:0] rs1_idx, rs2_idx;
  logic [xlen-1:0]          rs1_val, rs2_val;

  mem_mgmt_unit u_mmu (
    .clk_in, .rst_in, .rdy_in,
    .mem_din, .mem_dout, .mem_a, .mem_wr,
    .fetch_req, .fetch_addr, .fetch_done, .fetch_word,
    .store_req, .store_busy
  );

  inst_fetcher u_fetch (
    .clk_in, .rst_in, .rdy_in,
    .fetch_req, .fetch_addr, .fetch_done, .fetch_word,
    .store_busy, .fetch_out
  );

  decoder u_dec (
    .clk_in, .rst_in, .rdy_in,
    .fetch_out, .rs1_idx, .rs2_idx, .rs1_val, .rs2_val, .dec_out
  );

  alu_exec u_exec (
    .clk_in, .rst_in, .rdy_in,
    .dec_out, .exec_out, .store_req
  );

  writeback u_wb (
    .clk_in, .rst_in, .rdy_in,
    .exec_out, .rs1_idx, .rs2_idx, .rs1_val, .rs2_val, .dbgreg_dout
  );

endmodule

// ==== rtl/cpu_pkg.sv ====
/*
 * shared definitions for the cut-down rv32i core:
 * widths, major opcodes, alu operation codes and the
 * packed structs passed between the pipeline stages
 */
package cpu_pkg;

  localparam int xlen          = 32;  // data width
  localparam int addr_bits     = 32;  // external address width
  localparam int reg_addr_bits = 5;   // register index

  // major opcodes handled by the core
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_lui   = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_store = 7'b0100011;

  localparam logic [addr_bits-1:0] reset_pc = '0;  // first fetch address

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and,
    alu_pass_b                       // lui passes operand b through
  } alu_op_t;

  // fetched instruction with its pc
  typedef struct packed {
    logic                 valid;
    logic [addr_bits-1:0] pc;
    logic [xlen-1:0]      inst;
  } fetch_t;

  typedef struct packed {
    logic                     valid;
    alu_op_t                  alu_op;
    logic [xlen-1:0]          op_a;        // rs1, or pc for auipc
    logic [xlen-1:0]          op_b;        // rs2 or immediate
    logic [xlen-1:0]          store_data;  // rs2 for sw
    logic [reg_addr_bits-1:0] rd;
    logic                     wr_en;
    logic                     is_store;
  } decoded_t;

  typedef struct packed {
    logic                     valid;
    logic [reg_addr_bits-1:0] rd;
    logic                     wr_en;
    logic [xlen-1:0]          result;
  } exec_t;

  // word store handed to the bus sequencer
  typedef struct packed {
    logic                 valid;
    logic [addr_bits-1:0] addr;
    logic [xlen-1:0]      data;
  } store_req_t;

endpackage

// ==== rtl/decoder.sv ====
/*
 * decode stage
 * splits the instruction fields, builds the i, s and u immediates,
 * reads rs1/rs2 and registers the selected alu operation and operands
 */
`timescale 1ns/1ns

module decoder
  import cpu_pkg::*;
(
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     rdy_in,
  input  fetch_t                   fetch_out,
  output logic [reg_addr_bits-1:0] rs1_idx,
  output logic [reg_addr_bits-1:0] rs2_idx,
  input  logic [xlen-1:0]          rs1_val,
  input  logic [xlen-1:0]          rs2_val,
  output decoded_t                 dec_out
);

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [reg_addr_bits-1:0] rd;
  logic [xlen-1:0]          imm_i, imm_s, imm_u;
  logic                     is_reg;
  alu_op_t                  alu_fn;
  decoded_t                 dec_next;

  assign opcode  = fetch_out.inst[6:0];
  assign rd      = fetch_out.inst[11:7];
  assign funct3  = fetch_out.inst[14:12];
  assign rs1_idx = fetch_out.inst[19:15];  // register file read is combinational
  assign rs2_idx = fetch_out.inst[24:20];
  assign funct7  = fetch_out.inst[31:25];
  assign is_reg  = (opcode == op_reg);

  assign imm_i = {{20{fetch_out.inst[31]}}, fetch_out.inst[31:20]};
  assign imm_s = {{20{fetch_out.inst[31]}}, fetch_out.inst[31:25], fetch_out.inst[11:7]};
  assign imm_u = {fetch_out.inst[31:12], 12'b0};

  always_comb begin
    case (funct3)
      3'b000:  alu_fn = (is_reg && funct7[5]) ? alu_sub : alu_add;  // addi never subtracts
      3'b001:  alu_fn = alu_sll;
      3'b010:  alu_fn = alu_slt;
      3'b011:  alu_fn = alu_sltu;
      3'b100:  alu_fn = alu_xor;
      3'b101:  alu_fn = funct7[5] ? alu_sra : alu_srl;  // srai carries bit 30 too
      3'b110:  alu_fn = alu_or;
      default: alu_fn = alu_and;
    endcase
  end

  always_comb begin
    dec_next       = '0;
    dec_next.valid = fetch_out.valid;
    dec_next.rd    = rd;
    case (opcode)
      op_imm: begin
        dec_next.alu_op = alu_fn;
        dec_next.op_a   = rs1_val;
        dec_next.op_b   = imm_i;
        dec_next.wr_en  = 1'b1;
      end
      op_reg: begin
        dec_next.alu_op = alu_fn;
        dec_next.op_a   = rs1_val;
        dec_next.op_b   = rs2_val;
        dec_next.wr_en  = 1'b1;
      end
      op_lui: begin
        dec_next.alu_op = alu_pass_b;
        dec_next.op_b   = imm_u;
        dec_next.wr_en  = 1'b1;
      end
      op_auipc: begin
        dec_next.alu_op = alu_add;
        dec_next.op_a   = fetch_out.pc;
        dec_next.op_b   = imm_u;
        dec_next.wr_en  = 1'b1;
      end
      op_store: begin  // sw only
        dec_next.alu_op     = alu_add;
        dec_next.op_a       = rs1_val;
        dec_next.op_b       = imm_s;
        dec_next.store_data = rs2_val;
        dec_next.is_store   = 1'b1;
      end
      default:  dec_next.wr_en = 1'b0;  // retires as a no-op
    endcase
    if (rd == '0) dec_next.wr_en = 1'b0;  // x0 stays zero
  end

  always_ff @(posedge clk_in) begin
    if (rst_in)      dec_out <= '0;
    else if (rdy_in) dec_out <= dec_next;
  end

endmodule

// ==== rtl/inst_fetcher.sv ====
/*
 * instruction fetcher
 * keeps the pc, requests words from the bus sequencer and
 * hands each fetched instruction on as a one-cycle item
 */
`timescale 1ns/1ns

module inst_fetcher
  import cpu_pkg::*;
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 rdy_in,
  output logic                 fetch_req,
  output logic [addr_bits-1:0] fetch_addr,
  input  logic                 fetch_done,
  input  logic [xlen-1:0]      fetch_word,
  input  logic                 store_busy,
  output fetch_t               fetch_out
);

  logic [addr_bits-1:0] pc;

  assign fetch_addr = pc;  // held with fetch_req

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc        <= reset_pc;
      fetch_req <= 1'b0;
      fetch_out <= '0;
    end else if (rdy_in) begin
      fetch_out.valid <= 1'b0;
      if (fetch_req) begin
        if (fetch_done) begin
          fetch_out <= '{valid: 1'b1, pc: pc, inst: fetch_word};
          pc        <= pc + 32'd4;
          fetch_req <= !store_busy;  // no new fetch while a store owns the bus
        end
      end else if (!store_busy) begin
        fetch_req <= 1'b1;  // resume after the store drains
      end
    end
  end

endmodule

// ==== rtl/mem_mgmt_unit.sv ====
/*
 * byte-serial memory bus sequencer
 * reads instruction words as four pipelined byte reads and
 * writes sw stores as four byte writes
 * a pending store wins over a new fetch
 */
`timescale 1ns/1ns

module mem_mgmt_unit
  import cpu_pkg::*;
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 rdy_in,
  input  logic [7:0]           mem_din,
  output logic [7:0]           mem_dout,
  output logic [addr_bits-1:0] mem_a,
  output logic                 mem_wr,
  input  logic                 fetch_req,
  input  logic [addr_bits-1:0] fetch_addr,
  output logic                 fetch_done,
  output logic [xlen-1:0]      fetch_word,
  input  store_req_t           store_req,
  output logic                 store_busy
);

  typedef enum logic [1:0] {st_idle, st_fetch, st_store} state_t;

  state_t               state;
  logic [2:0]           cnt;         // byte counter
  logic [xlen-1:0]      shift_q;     // fetch assembly or store bytes still to send
  logic                 pend_valid;  // store waiting for the bus
  logic [addr_bits-1:0] pend_addr;
  logic [xlen-1:0]      pend_data;
  logic                 rdy_q;       // rdy_in one edge back
  logic [7:0]           din_q;       // byte returned by the last active edge
  logic [7:0]           byte_in;

  // the ram answers mem_a every edge, paused or not, so after a pause
  // the byte that belongs to the pipeline sits in din_q
  assign byte_in    = rdy_q ? mem_din : din_q;
  assign store_busy = pend_valid | (state == st_store);
  assign fetch_word = shift_q;  // little-endian with byte 0 in [7:0]

  always_ff @(posedge clk_in) begin
    if (rst_in) rdy_q <= 1'b0;
    else        rdy_q <= rdy_in;
  end

  always_ff @(posedge clk_in) begin
    if (rdy_q) din_q <= mem_din;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= st_idle;
      cnt        <= '0;
      mem_a      <= '0;
      mem_wr     <= 1'b0;
      mem_dout   <= '0;
      fetch_done <= 1'b0;
      pend_valid <= 1'b0;
    end else if (rdy_in) begin
      fetch_done <= 1'b0;  // one-cycle pulse
      case (state)
        st_idle: begin
          if (pend_valid) begin  // store first
            state      <= st_store;
            mem_wr     <= 1'b1;
            mem_a      <= pend_addr;
            mem_dout   <= pend_data[7:0];
            shift_q    <= pend_data >> 8;
            cnt        <= 3'd1;
            pend_valid <= 1'b0;
          end else if (fetch_req && !fetch_done) begin  // skip the request just served
            state <= st_fetch;
            mem_a <= fetch_addr;
            cnt   <= '0;
          end
        end
        st_fetch: begin
          if (cnt < 3'd3) mem_a <= mem_a + 1'b1;                  // next byte address
          if (cnt != 3'd0) shift_q <= {byte_in, shift_q[xlen-1:8]};  // byte lands one edge later
          if (cnt == 3'd4) begin
            fetch_done <= 1'b1;
            state      <= st_idle;
          end
          cnt <= cnt + 3'd1;
        end
        st_store: begin
          if (cnt == 3'd4) begin  // four write cycles done
            mem_wr <= 1'b0;
            state  <= st_idle;
          end else begin
            mem_a    <= mem_a + 1'b1;
            mem_dout <= shift_q[7:0];
            shift_q  <= shift_q >> 8;
            cnt      <= cnt + 3'd1;
          end
        end
        default: state <= st_idle;
      endcase
      // a second sw can arrive while the first one is on the bus
      if (store_req.valid) begin
        pend_valid <= 1'b1;
        pend_addr  <= store_req.addr;
        pend_data  <= store_req.data;
      end
    end
  end

endmodule

// ==== rtl/writeback.sv ====
/*
 * result stage with the 32 x 32 register file
 * combinational rs1/rs2 reads, x0 tied to zero,
 * every register write is mirrored on the debug output
 */
`timescale 1ns/1ns

module writeback
  import cpu_pkg::*;
(
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     rdy_in,
  input  exec_t                    exec_out,
  input  logic [reg_addr_bits-1:0] rs1_idx,
  input  logic [reg_addr_bits-1:0] rs2_idx,
  output logic [xlen-1:0]          rs1_val,
  output logic [xlen-1:0]          rs2_val,
  output logic [xlen-1:0]          dbgreg_dout
);

  logic [xlen-1:0] regs [32];
  logic            do_write;

  // x0 is never written
  assign do_write = exec_out.valid && exec_out.wr_en && (exec_out.rd != '0);

  assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      dbgreg_dout <= '0;
    end else if (rdy_in) begin
      if (do_write) begin
        regs[exec_out.rd] <= exec_out.result;
        dbgreg_dout       <= exec_out.result;  // last nonzero-register write
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the core and its testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_cpu \
  -Mdir obj_dir -o tb_cpu > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== sources.f ====
rtl/cpu_pkg.sv
rtl/mem_mgmt_unit.sv
rtl/inst_fetcher.sv
rtl/decoder.sv
rtl/alu_exec.sv
rtl/writeback.sv
rtl/cpu.sv
bench/tb_cpu.sv
